// File: src.f
mulPkg.sv
mulControl.sv
mulAddSub.sv
mulRegUnit.sv
mulTop.sv
mulTb_asserts.sv
mulTb.sv

// File: mulTb.sv
module mulTb;

	localparam int Width = 8;
	localparam int ProdW = 2 * Width;
	localparam int ResetCycles = 5;
	localparam int NumRandom = 200;
	localparam int NumCorner = 5;
	localparam int NumRuns = NumRandom + NumCorner + 2; // Two chained runs at the end
	localparam int CycleLimit = NumRuns * (2 * Width + 8) + ResetCycles;
	localparam int RunLatency = 1 + 2 * Width; // Edges from Run sample to Done

	localparam logic [Width-1:0] MinVal = {1'b1, {(Width - 1){1'b0}}};
	localparam logic [Width-1:0] MaxVal = {1'b0, {(Width - 1){1'b1}}};
	localparam logic [Width-1:0] AllOnes = '1;
	localparam logic [Width-1:0] Zero = '0;

	logic             Clk;
	logic             rst;
	logic             Run;
	logic             ClearALoadB;
	logic [Width-1:0] Sw;
	logic [Width-1:0] A;
	logic [Width-1:0] B;
	logic             X;
	logic             Done;

	logic [31:0]      rngState;  // Xorshift state
	logic [Width-1:0] modelB;    // Multiplier the DUT should hold in B
	int               cycleCount;

	logic [Width-1:0] cornerB [NumCorner]; // Multipliers
	logic [Width-1:0] cornerS [NumCorner]; // Multiplicands

	mulTop #(
		.Width(Width)
	) DUT (
		.Clk        (Clk),
		.rst        (rst),
		.Run        (Run),
		.ClearALoadB(ClearALoadB),
		.Sw         (Sw),
		.A          (A),
		.B          (B),
		.X          (X),
		.Done       (Done)
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [Width-1:0] randomOperand();
		rngState = xorshift32(rngState);
		return rngState[Width-1:0];
	endfunction

	task automatic abortRun();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkProduct(input logic [ProdW-1:0] got, input logic [ProdW-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("FAIL t=%0t: %s, {A,B} is %h, expected %h", $time, what, got, exp);
			abortRun();
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL t=%0t: %s is %b, expected %b", $time, what, got, exp);
			abortRun();
		end
	endtask

	task automatic checkLatency(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("FAIL t=%0t: %s, Done after %0d edges, expected %0d",
				$time, what, got, exp);
			abortRun();
		end
	endtask

	////////////////////
	// Operations
	////////////////////

	// Pulse ClearALoadB for one cycle while Idle
	task automatic loadMultiplier(input logic [Width-1:0] value);
		Sw = value;
		ClearALoadB = 1'b1;
		@(negedge Clk);
		ClearALoadB = 1'b0;
		modelB = value;
		checkProduct({A, B}, {Zero, value}, "after B load");
		checkFlag(X, 1'b0, "X after B load");
	endtask

	// Multiply modelB by mcand, then hold and release Run
	task automatic runAndCheck(input logic [Width-1:0] mcand, input string tag);
		int               mulA;
		int               mulB;
		int               prod;
		int               latency;
		logic [ProdW-1:0] expProduct;
		logic             expX;
		mulA = $signed(modelB);
		mulB = $signed(mcand);
		prod = mulA * mulB;
		expProduct = ProdW'(prod);
		expX = (expProduct == '0) ? 1'b0 : expProduct[ProdW-1];
		Sw = mcand;
		Run = 1'b1;
		@(posedge Clk); // Edge that samples Run
		@(negedge Clk);
		latency = 0;
		while (Done !== 1'b1) begin
			@(negedge Clk);
			latency++;
		end
		checkLatency(latency, RunLatency, tag);
		checkProduct({A, B}, expProduct, tag);
		checkFlag(X, expX, "X");
		repeat (2) @(negedge Clk); // Run still high
		checkFlag(Done, 1'b1, "Done while Run held");
		checkProduct({A, B}, expProduct, "hold with Run high");
		Run = 1'b0;
		@(negedge Clk);
		checkFlag(Done, 1'b0, "Done after Run low");
		checkProduct({A, B}, expProduct, "hold after Run low");
		modelB = expProduct[Width-1:0]; // Low half stays as next multiplier
	endtask

	////////////////////
	// Timeout
	////////////////////

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge Clk);
			cycleCount++;
		end
		$display("ERROR: Done never arrived, cycle limit of %0d reached", CycleLimit);
		abortRun();
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst = 1'b1;
		Run = 1'b0;
		ClearALoadB = 1'b0;
		Sw = '0;
		rngState = 32'd18252;
		modelB = '0;
		cornerB = '{MinVal, MinVal, MaxVal, Zero, AllOnes};
		cornerS = '{MinVal, MaxVal, AllOnes, MinVal, AllOnes};

		repeat (ResetCycles) @(negedge Clk);
		rst = 1'b0;
		checkFlag(Done, 1'b0, "Done after reset");
		checkFlag(X, 1'b0, "X after reset");
		checkProduct({A, B}, '0, "after reset");

		for (int i = 0; i < NumRandom; i++) begin
			loadMultiplier(randomOperand());
			runAndCheck(randomOperand(), "random pair");
		end

		for (int i = 0; i < NumCorner; i++) begin
			loadMultiplier(cornerB[i]);
			runAndCheck(cornerS[i], "corner pair");
		end

		// Second Run reuses the low half left in B
		loadMultiplier(randomOperand());
		runAndCheck(randomOperand(), "chain first run");
		runAndCheck(randomOperand(), "chain second run");

		if (DUT.control.asserts.errorCount == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("ERROR: %0d control word assertions failed",
				DUT.control.asserts.errorCount);
			$display("Test failed");
			$fatal(1, "assertion failures were recorded");
		end
	end

endmodule

// File: mulTb_asserts.sv
module mulTb_asserts (
	input logic              Clk,
	input logic              rst,
	input mulPkg::mulCtrl_t  ctrl,
	input logic              Done,
	input logic              lastBit,
	input mulPkg::mulState_t state
);

	int errorCount = 0; // Failed assertions so far

	////////////////////
	// Control word
	////////////////////

	// Datapath actions never overlap
	assert property (@(posedge Clk) disable iff (rst)
		$onehot0({ctrl.add, ctrl.sub, ctrl.shift}))
		else begin
			errorCount++;
			$error("more than one of add, sub and shift set");
		end

	assert property (@(posedge Clk) disable iff (rst)
		ctrl.sub |-> (state == mulPkg::Op) && lastBit)
		else begin
			errorCount++;
			$error("sub outside the last bit");
		end

	// Result is frozen while Done is up
	assert property (@(posedge Clk) disable iff (rst)
		Done |-> ctrl == mulPkg::CtrlNone)
		else begin
			errorCount++;
			$error("control word active while Done is high");
		end

endmodule

bind mulControl mulTb_asserts asserts (
	.Clk    (Clk),
	.rst    (rst),
	.ctrl   (ctrl),
	.Done   (Done),
	.lastBit(lastBit),
	.state  (state)
);

// File: mulTop.sv
module mulTop #(
	parameter int Width = 8
) (
	input  logic             Clk,
	input  logic             rst,
	input  logic             Run,         // Start a multiply, held high
	input  logic             ClearALoadB, // Load B from Sw in Idle
	input  logic [Width-1:0] Sw,          // Multiplier, then multiplicand
	output logic [Width-1:0] A,
	output logic [Width-1:0] B,
	output logic             X,
	output logic             Done
);

	mulPkg::mulCtrl_t ctrl; // Control word for the datapath
	logic [Width:0]   sum;  // Next {X, A} on add or subtract

	////////////////////
	// Control unit
	////////////////////

	mulControl #(
		.Width(Width)
	) control (
		.Clk        (Clk),
		.rst        (rst),
		.Run        (Run),
		.ClearALoadB(ClearALoadB),
		.M          (B[0]),
		.ctrl       (ctrl),
		.Done       (Done)
	);

	////////////////////
	// Datapath
	////////////////////

	mulAddSub #(
		.Width(Width)
	) addSub (
		.A   (A),
		.S   (Sw),
		.ctrl(ctrl),
		.sum (sum)
	);

	mulRegUnit #(
		.Width(Width)
	) regUnit (
		.Clk (Clk),
		.rst (rst),
		.ctrl(ctrl),
		.sum (sum),
		.Sw  (Sw),
		.A   (A),
		.B   (B),
		.X   (X)
	);

endmodule

// File: mulRegUnit.sv
module mulRegUnit #(
	parameter int Width = 8
) (
	input  logic             Clk,
	input  logic             rst,
	input  mulPkg::mulCtrl_t ctrl,
	input  logic [Width:0]   sum,  // From the add/subtract unit
	input  logic [Width-1:0] Sw,
	output logic [Width-1:0] A,    // Product, upper half
	output logic [Width-1:0] B,    // Multiplier, then product lower half
	output logic             X     // Sign of X:A
);

	logic [Width-1:0] aShift; // A after one arithmetic shift
	logic [Width-1:0] bShift; // B after one shift

	////////////////////
	// Shift network
	////////////////////

	// X:A:B moves right by one, X stays as the sign
	assign aShift = {X, A[Width-1:1]};
	assign bShift = {A[0], B[Width-1:1]};

	////////////////////
	// X and A
	////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			X <= 1'b0;
			A <= '0;
		end else if (ctrl.clrAX) begin
			X <= 1'b0;
			A <= '0;
		end else if (ctrl.add | ctrl.sub) begin
			X <= sum[Width];       // Sign of the new partial product
			A <= sum[Width-1:0];
		end else if (ctrl.shift) begin
			A <= aShift;           // X keeps its value
		end
	end

	////////////////////
	// B
	////////////////////

	// Loaded only in Idle, so a load never meets a shift
	always_ff @(posedge Clk) begin
		if (rst) begin
			B <= '0;
		end else if (ctrl.ldB) begin
			B <= Sw;
		end else if (ctrl.shift) begin
			B <= bShift;           // Next multiplier bit into B[0]
		end
	end

endmodule

// File: mulAddSub.sv
module mulAddSub #(
	parameter int Width = 8
) (
	input  logic [Width-1:0] A,    // Partial product, upper half
	input  logic [Width-1:0] S,    // Multiplicand from the switches
	input  mulPkg::mulCtrl_t ctrl,
	output logic [Width:0]   sum   // New {X, A}
);

	logic [Width:0] aExt;    // A with one sign bit added
	logic [Width:0] sExt;    // S with one sign bit added
	logic [Width:0] operand; // S or its ones' complement
	logic [Width:0] carryIn; // 1 when subtracting

	////////////////////
	// Sign extension
	////////////////////

	// One extra bit keeps the true sign when A + S leaves the Width range
	assign aExt = {A[Width-1], A};
	assign sExt = {S[Width-1], S};

	////////////////////
	// Add or subtract
	////////////////////

	// Subtract is A + ~S + 1
	always_comb begin
		if (ctrl.sub) begin
			operand = ~sExt;
			carryIn = {{Width{1'b0}}, 1'b1};
		end else begin
			operand = sExt;
			carryIn = '0;
		end
	end

	assign sum = aExt + operand + carryIn; // Top bit goes to X

endmodule

// File: mulControl.sv
module mulControl #(
	parameter int Width = 8
) (
	input  logic             Clk,
	input  logic             rst,
	input  logic             Run,
	input  logic             ClearALoadB,
	input  logic             M,           // Current multiplier bit, B[0]
	output mulPkg::mulCtrl_t ctrl,
	output logic             Done
);

	// Bit counter sized from the operand width
	localparam int CntW = $clog2(Width);
	localparam logic [CntW-1:0] LastIdx = CntW'(Width - 1);

	mulPkg::mulState_t state;
	mulPkg::mulState_t nextState;

	logic [CntW-1:0] bitCnt; // Index of the bit being processed
	logic            lastBit; // Sign bit of the multiplier

	assign lastBit = (bitCnt == LastIdx);

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= mulPkg::Idle;
		end else begin
			state <= nextState;
		end
	end

	// Cleared on Start, advanced once per Shift cycle
	always_ff @(posedge Clk) begin
		if (rst) begin
			bitCnt <= '0;
		end else if (state == mulPkg::Start) begin
			bitCnt <= '0;
		end else if (state == mulPkg::Shift) begin
			bitCnt <= bitCnt + CntW'(1);
		end
	end

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		nextState = state;
		unique case (state)
			mulPkg::Idle: begin
				if (Run) begin
					nextState = mulPkg::Start;
				end
			end
			mulPkg::Start: begin
				nextState = mulPkg::Op; // A and X cleared at this edge
			end
			mulPkg::Op: begin
				nextState = mulPkg::Shift; // Every bit gets one Op cycle
			end
			mulPkg::Shift: begin
				if (lastBit) begin
					nextState = mulPkg::Done;
				end else begin
					nextState = mulPkg::Op;
				end
			end
			mulPkg::Done: begin
				if (!Run) begin
					nextState = mulPkg::Idle; // Wait for Run to fall
				end
			end
			default: begin
				nextState = mulPkg::Idle;
			end
		endcase
	end

	////////////////////
	// Control decode
	////////////////////

	// The sign bit of the multiplier carries negative weight, so the
	// last Op cycle subtracts the multiplicand instead of adding it
	always_comb begin
		ctrl = mulPkg::CtrlNone;
		unique case (state)
			mulPkg::Idle: begin
				ctrl.ldB   = ClearALoadB;
				ctrl.clrAX = ClearALoadB;
			end
			mulPkg::Start: begin
				ctrl.clrAX = 1'b1;
			end
			mulPkg::Op: begin
				ctrl.add = M & ~lastBit;
				ctrl.sub = M & lastBit;
			end
			mulPkg::Shift: begin
				ctrl.shift = 1'b1;
			end
			default: begin
				ctrl = mulPkg::CtrlNone; // Done holds the result
			end
		endcase
	end

	////////////////////
	// Done flag
	////////////////////

	// High for exactly the cycles spent in the Done state
	always_ff @(posedge Clk) begin
		if (rst) begin
			Done <= 1'b0;
		end else begin
			Done <= (nextState == mulPkg::Done);
		end
	end

endmodule

// File: mulPkg.sv
package mulPkg;

	////////////////////
	// Control states
	////////////////////

	// Sequencer states of the multiplier control unit
	typedef enum logic [2:0] {
		Idle  = 3'd0, // Waiting, B load allowed
		Start = 3'd1, // Clear A and X
		Op    = 3'd2, // Add or subtract on current bit
		Shift = 3'd3, // Shift X:A:B right
		Done  = 3'd4  // Hold product until Run drops
	} mulState_t;

	////////////////////
	// Control word
	////////////////////

	// One bit per datapath action, decoded every cycle by the control unit.
	// At most one of shift, add and sub is set in any cycle.
	typedef struct packed {
		logic clrAX; // Zero A and X
		logic ldB;   // B <= Sw
		logic shift; // Arithmetic shift of X:A:B
		logic add;   // X:A <= A + Sw
		logic sub;   // X:A <= A - Sw
	} mulCtrl_t;

	localparam mulCtrl_t CtrlNone = '0; // No datapath action

endpackage
